// File: Bender.yml
package:
  name: core

sources:
  # Core RTL, package first
  - files:
      - hdl/core_pkg.sv
      - hdl/fetch_unit.sv
      - hdl/instr_queue.sv
      - hdl/exec_unit.sv
      - hdl/mem_port_mux.sv
      - hdl/core_top.sv

  # Testbench with memory model
  - target: test
    files:
      - testbench/tb_mem_model.sv
      - testbench/tb_core.sv

// File: hdl/core_pkg.sv
package core_pkg;

   typedef logic [31:0] word_t;
   typedef logic [29:0] word_addr_t;
   typedef logic [2:0]  reg_idx_t;
   typedef logic [1:0]  mem_id_t;
   typedef logic [3:0]  byte_mask_t;

   // Tag 0 means no return this cycle
   localparam mem_id_t ID_DC = 2'd1;
   localparam mem_id_t ID_IC = 2'd2;

   localparam word_addr_t BOOT_ADDR = 30'd0;

   localparam int QUEUE_DEPTH = 4;
   localparam int PTR_W       = $clog2(QUEUE_DEPTH);
   localparam int CNT_W       = $clog2(QUEUE_DEPTH + 1);

   typedef logic [PTR_W-1:0] qptr_t;
   typedef logic [CNT_W-1:0] slot_cnt_t;

   // Instruction field positions
   localparam int OP_MSB  = 31;
   localparam int OP_LSB  = 28;
   localparam int RD_MSB  = 27;
   localparam int RD_LSB  = 25;
   localparam int RS_MSB  = 24;
   localparam int RS_LSB  = 22;
   localparam int RT_MSB  = 21;
   localparam int RT_LSB  = 19;
   localparam int IMM_MSB = 15;
   localparam int IMM_LSB = 0;

   // Unlisted codes execute as no-ops
   typedef enum logic [3:0] {
      OP_ADD  = 4'h1,
      OP_SUB  = 4'h2,
      OP_ADDI = 4'h3,
      OP_LW   = 4'h4,
      OP_SW   = 4'h5,
      OP_BEQ  = 4'h6,
      OP_HALT = 4'h7
   } opcode_t;

   typedef struct packed {
      word_addr_t addr;
      word_t      instr;
   } fetch_item_t;

   typedef struct packed {
      logic       read;
      logic       write;
      word_addr_t addr;
      word_t      wdata;
      byte_mask_t mask;
   } mem_req_t;

endpackage

// File: hdl/core_top.sv
`timescale 1ns/1ps

module core_top (
   input  logic               clock,
   input  logic               i_arst_n,
   output core_pkg::mem_req_t o_mem_req,
   output core_pkg::mem_id_t  o_mem_id,
   input  logic               i_mem_waitrequest,
   input  core_pkg::word_t    i_mem_rdata,
   input  core_pkg::mem_id_t  i_mem_rid,
   output logic               o_halted
);

   core_pkg::mem_req_t    ireq;
   core_pkg::mem_req_t    dreq;
   logic                  iwait;
   logic                  dwait;
   core_pkg::word_t       irdata;
   core_pkg::word_t       drdata;
   logic                  irvalid;
   logic                  drvalid;
   core_pkg::fetch_item_t f_item;
   logic                  f_valid;
   logic                  f_ready;
   core_pkg::fetch_item_t q_item;
   logic                  q_valid;
   logic                  q_ready;
   core_pkg::slot_cnt_t   free_slots;
   logic                  redirect;
   core_pkg::word_addr_t  redirect_addr;

   fetch_unit u_fetch (
      .clock           (clock),
      .i_arst_n        (i_arst_n),
      .i_redirect      (redirect),
      .i_redirect_addr (redirect_addr),
      .o_req           (ireq),
      .i_waitrequest   (iwait),
      .i_rdata         (irdata),
      .i_rvalid        (irvalid),
      .o_item          (f_item),
      .o_valid         (f_valid),
      .i_ready         (f_ready),
      .i_free_slots    (free_slots)
   );

   // Redirect also flushes the queue
   instr_queue u_queue (
      .clock        (clock),
      .i_arst_n     (i_arst_n),
      .i_item       (f_item),
      .i_valid      (f_valid),
      .o_ready      (f_ready),
      .o_item       (q_item),
      .o_valid      (q_valid),
      .i_ready      (q_ready),
      .i_flush      (redirect),
      .o_free_slots (free_slots)
   );

   exec_unit u_exec (
      .clock           (clock),
      .i_arst_n        (i_arst_n),
      .i_item          (q_item),
      .i_valid         (q_valid),
      .o_ready         (q_ready),
      .o_req           (dreq),
      .i_waitrequest   (dwait),
      .i_rdata         (drdata),
      .i_rvalid        (drvalid),
      .o_redirect      (redirect),
      .o_redirect_addr (redirect_addr),
      .o_halted        (o_halted)
   );

   mem_port_mux u_mux (
      .i_ireq            (ireq),
      .o_iwait           (iwait),
      .o_irdata          (irdata),
      .o_irvalid         (irvalid),
      .i_dreq            (dreq),
      .o_dwait           (dwait),
      .o_drdata          (drdata),
      .o_drvalid         (drvalid),
      .o_mem_req         (o_mem_req),
      .o_mem_id          (o_mem_id),
      .i_mem_waitrequest (i_mem_waitrequest),
      .i_mem_rdata       (i_mem_rdata),
      .i_mem_rid         (i_mem_rid)
   );

endmodule

// File: hdl/exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
   input  logic                  clock,
   input  logic                  i_arst_n,
   input  core_pkg::fetch_item_t i_item,
   input  logic                  i_valid,
   output logic                  o_ready,
   output core_pkg::mem_req_t    o_req,
   input  logic                  i_waitrequest,
   input  core_pkg::word_t       i_rdata,
   input  logic                  i_rvalid,
   output logic                  o_redirect,
   output core_pkg::word_addr_t  o_redirect_addr,
   output logic                  o_halted
);

   typedef enum logic [1:0] {
      S_RUN,
      S_WAIT_STORE,
      S_WAIT_LOAD,
      S_HALTED
   } state_t;

   state_t               state;
   core_pkg::word_t      regs [8];
   logic                 rd_q;
   logic                 wr_q;
   logic                 redirect_q;
   core_pkg::word_addr_t addr_q;
   core_pkg::word_t      wdata_q;
   core_pkg::reg_idx_t   ld_rd_q;
   core_pkg::word_addr_t redirect_addr_q;

   core_pkg::opcode_t    op;
   core_pkg::reg_idx_t   rd;
   core_pkg::reg_idx_t   rs;
   core_pkg::reg_idx_t   rt;
   core_pkg::word_t      imm;
   core_pkg::word_t      rs_val;
   core_pkg::word_t      rt_val;
   core_pkg::word_t      alu_res;
   core_pkg::word_t      ea;
   core_pkg::word_t      target;
   logic                 accept;
   logic                 alu_we;
   logic                 ld_we;

   assign op  = core_pkg::opcode_t'(i_item.instr[core_pkg::OP_MSB:core_pkg::OP_LSB]);
   assign rd  = i_item.instr[core_pkg::RD_MSB:core_pkg::RD_LSB];
   assign rs  = i_item.instr[core_pkg::RS_MSB:core_pkg::RS_LSB];
   assign rt  = i_item.instr[core_pkg::RT_MSB:core_pkg::RT_LSB];
   assign imm = {{16{i_item.instr[core_pkg::IMM_MSB]}},
                 i_item.instr[core_pkg::IMM_MSB:core_pkg::IMM_LSB]};

   // r0 is hardwired to zero
   assign rs_val = (rs == '0) ? '0 : regs[rs];
   assign rt_val = (rt == '0) ? '0 : regs[rt];

   always_comb begin
      case (op)
         core_pkg::OP_SUB:  alu_res = rs_val - rt_val;
         core_pkg::OP_ADDI: alu_res = rs_val + imm;
         default:           alu_res = rs_val + rt_val;
      endcase
   end

   assign ea     = rs_val + imm;
   assign target = {2'b00, i_item.addr} + 32'd1 + imm;

   // Hold off while the redirect is still flushing the queue
   assign o_ready = (state == S_RUN) && !redirect_q;
   assign accept  = i_valid && o_ready;
   assign alu_we  = accept && (op == core_pkg::OP_ADD || op == core_pkg::OP_SUB ||
                               op == core_pkg::OP_ADDI);
   assign ld_we   = (state == S_WAIT_LOAD) && i_rvalid;

   always_comb begin
      o_req       = '0;
      o_req.read  = rd_q;
      o_req.write = wr_q;
      o_req.addr  = addr_q;
      o_req.wdata = wdata_q;
      o_req.mask  = wr_q ? '1 : '0;
   end

   assign o_redirect      = redirect_q;
   assign o_redirect_addr = redirect_addr_q;
   assign o_halted        = (state == S_HALTED);

   always_ff @(posedge clock or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state      <= S_RUN;
         rd_q       <= 1'b0;
         wr_q       <= 1'b0;
         redirect_q <= 1'b0;
      end else begin
         redirect_q <= 1'b0;
         case (state)
            S_RUN: begin
               if (accept) begin
                  case (op)
                     core_pkg::OP_LW: begin
                        rd_q  <= 1'b1;
                        state <= S_WAIT_LOAD;
                     end
                     core_pkg::OP_SW: begin
                        wr_q  <= 1'b1;
                        state <= S_WAIT_STORE;
                     end
                     core_pkg::OP_BEQ: begin
                        redirect_q <= (rs_val == rt_val);
                     end
                     core_pkg::OP_HALT: begin
                        state <= S_HALTED;
                     end
                     default: begin
                     end
                  endcase
               end
            end
            S_WAIT_STORE: begin
               if (!i_waitrequest) begin
                  wr_q  <= 1'b0;
                  state <= S_RUN;
               end
            end
            S_WAIT_LOAD: begin
               if (rd_q && !i_waitrequest) begin
                  rd_q <= 1'b0;
               end
               // Load ends on its tagged return
               if (i_rvalid) begin
                  state <= S_RUN;
               end
            end
            default: begin
               state <= S_HALTED;
            end
         endcase
      end
   end

   always_ff @(posedge clock) begin
      if (accept && (op == core_pkg::OP_LW || op == core_pkg::OP_SW)) begin
         addr_q  <= ea[29:0];
         wdata_q <= rt_val;
         ld_rd_q <= rd;
      end
      if (accept && op == core_pkg::OP_BEQ) begin
         redirect_addr_q <= target[29:0];
      end
      if (ld_we) begin
         regs[ld_rd_q] <= i_rdata;
      end else if (alu_we) begin
         regs[rd] <= alu_res;
      end
   end

endmodule

// File: hdl/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
   input  logic                  clock,
   input  logic                  i_arst_n,
   input  logic                  i_redirect,
   input  core_pkg::word_addr_t  i_redirect_addr,
   output core_pkg::mem_req_t    o_req,
   input  logic                  i_waitrequest,
   input  core_pkg::word_t       i_rdata,
   input  logic                  i_rvalid,
   output core_pkg::fetch_item_t o_item,
   output logic                  o_valid,
   input  logic                  i_ready,
   input  core_pkg::slot_cnt_t   i_free_slots
);

   logic                 fetch_en;
   core_pkg::word_addr_t next_addr;
   core_pkg::slot_cnt_t  inflight;
   core_pkg::slot_cnt_t  inflight_next;
   core_pkg::slot_cnt_t  stale;
   core_pkg::qptr_t      wr_ptr;
   core_pkg::qptr_t      rd_ptr;
   core_pkg::word_addr_t addr_fifo [core_pkg::QUEUE_DEPTH];
   logic                 issue;

   // Only ask for what the queue can still take
   always_comb begin
      o_req       = '0;
      o_req.read  = fetch_en && i_ready && (i_free_slots > inflight);
      o_req.addr  = next_addr;
   end

   assign issue = o_req.read && !i_waitrequest;

   always_comb begin
      inflight_next = inflight;
      if (issue && !i_rvalid) begin
         inflight_next = inflight + 1'b1;
      end else if (!issue && i_rvalid) begin
         inflight_next = inflight - 1'b1;
      end
   end

   // Returned word paired with the oldest outstanding address
   assign o_item.addr  = addr_fifo[rd_ptr];
   assign o_item.instr = i_rdata;
   assign o_valid      = i_rvalid && (stale == '0);

   always_ff @(posedge clock or negedge i_arst_n) begin
      if (!i_arst_n) begin
         fetch_en  <= 1'b0;
         next_addr <= core_pkg::BOOT_ADDR;
         inflight  <= '0;
         stale     <= '0;
         wr_ptr    <= '0;
         rd_ptr    <= '0;
      end else begin
         fetch_en <= 1'b1;
         inflight <= inflight_next;
         if (issue) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (i_rvalid) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         if (i_redirect) begin
            // Everything still out there belongs to the old path
            next_addr <= i_redirect_addr;
            stale     <= inflight_next;
         end else begin
            if (issue) begin
               next_addr <= next_addr + 1'b1;
            end
            if (i_rvalid && stale != '0) begin
               stale <= stale - 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clock) begin
      if (issue) begin
         addr_fifo[wr_ptr] <= next_addr;
      end
   end

endmodule

// File: hdl/instr_queue.sv
`timescale 1ns/1ps

module instr_queue (
   input  logic                  clock,
   input  logic                  i_arst_n,
   input  core_pkg::fetch_item_t i_item,
   input  logic                  i_valid,
   output logic                  o_ready,
   output core_pkg::fetch_item_t o_item,
   output logic                  o_valid,
   input  logic                  i_ready,
   input  logic                  i_flush,
   output core_pkg::slot_cnt_t   o_free_slots
);

   localparam core_pkg::slot_cnt_t FULL = core_pkg::slot_cnt_t'(core_pkg::QUEUE_DEPTH);

   core_pkg::fetch_item_t entries [core_pkg::QUEUE_DEPTH];
   core_pkg::qptr_t       wr_ptr;
   core_pkg::qptr_t       rd_ptr;
   core_pkg::slot_cnt_t   count;
   logic                  push;
   logic                  pop;

   assign o_ready      = (count != FULL);
   assign o_valid      = (count != '0);
   assign o_item       = entries[rd_ptr];
   assign o_free_slots = FULL - count;

   assign push = i_valid && o_ready;
   assign pop  = o_valid && i_ready;

   always_ff @(posedge clock or negedge i_arst_n) begin
      if (!i_arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else if (i_flush) begin
         // Drop everything, including a push in this cycle
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         if (push && !pop) begin
            count <= count + 1'b1;
         end else if (pop && !push) begin
            count <= count - 1'b1;
         end
      end
   end

   always_ff @(posedge clock) begin
      if (push && !i_flush) begin
         entries[wr_ptr] <= i_item;
      end
   end

endmodule

// File: hdl/mem_port_mux.sv
`timescale 1ns/1ps

module mem_port_mux (
   input  core_pkg::mem_req_t i_ireq,
   output logic               o_iwait,
   output core_pkg::word_t    o_irdata,
   output logic               o_irvalid,
   input  core_pkg::mem_req_t i_dreq,
   output logic               o_dwait,
   output core_pkg::word_t    o_drdata,
   output logic               o_drvalid,
   output core_pkg::mem_req_t o_mem_req,
   output core_pkg::mem_id_t  o_mem_id,
   input  logic               i_mem_waitrequest,
   input  core_pkg::word_t    i_mem_rdata,
   input  core_pkg::mem_id_t  i_mem_rid
);

   logic dstrobe;

   // Data side wins whenever it has something
   assign dstrobe   = i_dreq.read || i_dreq.write;

   assign o_mem_req = dstrobe ? i_dreq : i_ireq;
   assign o_mem_id  = dstrobe ? core_pkg::ID_DC : core_pkg::ID_IC;

   assign o_dwait   = i_mem_waitrequest;
   assign o_iwait   = i_mem_waitrequest || dstrobe;

   // Returns steered by tag
   assign o_drdata  = i_mem_rdata;
   assign o_drvalid = (i_mem_rid == core_pkg::ID_DC);
   assign o_irdata  = i_mem_rdata;
   assign o_irvalid = (i_mem_rid == core_pkg::ID_IC);

endmodule

// File: testbench/core_golden.hex
// Words 0 to 23 program image, then the expected store count
// Then one expected store per line as word address and data
32000005 // addi r1, r0, 5
3400fffd // addi r2, r0, -3
16500000 // add  r3, r1, r2
28500000 // sub  r4, r1, r2
50180040 // sw   r3, 0x40(r0)
50200041 // sw   r4, 0x41(r0)
30000007 // addi r0, r0, 7
1a080000 // add  r5, r0, r1
50280042 // sw   r5, 0x42(r0)
50100043 // sw   r2, 0x43(r0)
4c000040 // lw   r6, 0x40(r0)
50300044 // sw   r6, 0x44(r0)
60500002 // beq  r1, r2, +2 not taken
50080045 // sw   r1, 0x45(r0)
61980002 // beq  r6, r3, +2 taken
50200046 // sw   r4, 0x46(r0) skipped
50200047 // sw   r4, 0x47(r0) skipped
2f080000 // sub  r7, r4, r1
50380048 // sw   r7, 0x48(r0)
37c0fff6 // addi r3, r7, -10
50180049 // sw   r3, 0x49(r0)
70000000 // halt
5008004a // sw   r1, 0x4a(r0) never runs
5008004b // sw   r1, 0x4b(r0) never runs
00000008
00000040 00000002
00000041 00000008
00000042 00000005
00000043 fffffffd
00000044 00000002
00000045 00000005
00000048 00000003
00000049 fffffff9

// File: testbench/tb_core.sv
`timescale 1ns/1ps

module tb_core;

   localparam int PROG_WORDS     = 24;
   localparam int COUNT_IDX      = PROG_WORDS;
   localparam int MAX_STORES     = 8;
   localparam int GOLDEN_WORDS   = PROG_WORDS + 1 + 2 * MAX_STORES;
   localparam int RESET_CYCLES   = 4;
   localparam int TIMEOUT_CYCLES = 200 * PROG_WORDS;
   localparam int DRAIN_CYCLES   = 16;

   logic               clock = 1'b0;
   logic               arst_n;
   core_pkg::mem_req_t mem_req;
   core_pkg::mem_id_t  mem_id;
   logic               mem_wait;
   core_pkg::word_t    mem_rdata;
   core_pkg::mem_id_t  mem_rid;
   logic               halted;

   core_pkg::word_t    golden [GOLDEN_WORDS];
   int                 store_count;
   int                 store_idx;
   int                 errors;
   int                 cycles;
   logic               halt_seen;
   logic               first_fetch;
   logic               dc_held;
   core_pkg::mem_req_t held_req;

   core_top UUT (
      .clock             (clock),
      .i_arst_n          (arst_n),
      .o_mem_req         (mem_req),
      .o_mem_id          (mem_id),
      .i_mem_waitrequest (mem_wait),
      .i_mem_rdata       (mem_rdata),
      .i_mem_rid         (mem_rid),
      .o_halted          (halted)
   );

   tb_mem_model u_mem (
      .clock         (clock),
      .i_req         (mem_req),
      .i_id          (mem_id),
      .o_waitrequest (mem_wait),
      .o_rdata       (mem_rdata),
      .o_rid         (mem_rid)
   );

   initial begin
      forever #10 clock = ~clock;
   end

   task automatic flag_mismatch(input string name, input core_pkg::word_t got,
                                input core_pkg::word_t expected);
      errors++;
      $display("[ERROR] %0t ns: %s = %h, expected %h", $time, name, got, expected);
   endtask

   task automatic note_failure(input string what);
      errors++;
      $display("Failure at %0t ns: %s", $time, what);
   endtask

   task automatic check_store(input core_pkg::word_addr_t addr, input core_pkg::word_t data);
      core_pkg::word_t exp_addr;
      core_pkg::word_t exp_data;
      assert (store_idx < store_count)
         else note_failure($sformatf("unexpected store to word %h", addr));
      if (store_idx < store_count) begin
         exp_addr = golden[COUNT_IDX + 1 + 2 * store_idx];
         exp_data = golden[COUNT_IDX + 2 + 2 * store_idx];
         assert ({2'b00, addr} == exp_addr)
            else flag_mismatch("o_mem_req.addr", {2'b00, addr}, exp_addr);
         assert (data == exp_data)
            else flag_mismatch("o_mem_req.wdata", data, exp_data);
      end
      store_idx++;
   endtask

   // Registered request is stable by the rising edge
   always @(posedge clock) begin
      if (arst_n) begin
         cycles++;
         if (cycles == 1) begin
            assert (!mem_req.read && !mem_req.write && !halted)
               else note_failure("bus strobe or o_halted high right after reset");
         end
         if (mem_req.read || mem_req.write) begin
            if (first_fetch) begin
               assert (mem_id == core_pkg::ID_IC && mem_req.addr == core_pkg::BOOT_ADDR)
                  else note_failure("first request is not a fetch at the boot address");
               first_fetch = 1'b0;
            end
            if (mem_id == core_pkg::ID_IC) begin
               assert (mem_req.read && !mem_req.write)
                  else note_failure("instruction tagged request is not a plain read");
            end
            if (mem_req.write) begin
               assert (mem_id == core_pkg::ID_DC)
                  else flag_mismatch("o_mem_id", 32'(mem_id), 32'(core_pkg::ID_DC));
            end
         end
         if (dc_held) begin
            assert (mem_id == core_pkg::ID_DC && mem_req == held_req)
               else note_failure("data request changed while waitrequest was high");
         end
         dc_held  = (mem_id == core_pkg::ID_DC) && mem_wait;
         held_req = mem_req;
         if (mem_req.write && !mem_wait) begin
            assert (mem_req.mask == 4'hf)
               else flag_mismatch("o_mem_req.mask", 32'(mem_req.mask), 32'hf);
            check_store(mem_req.addr, mem_req.wdata);
         end
         if (halt_seen) begin
            assert (halted)
               else note_failure("o_halted dropped before reset");
         end else if (halted) begin
            halt_seen = 1'b1;
            assert (store_idx == store_count)
               else note_failure($sformatf("o_halted rose after %0d of %0d stores",
                                           store_idx, store_count));
         end
      end
   end

   initial begin
      errors      = 0;
      store_idx   = 0;
      cycles      = 0;
      halt_seen   = 1'b0;
      first_fetch = 1'b1;
      dc_held     = 1'b0;
      held_req    = '0;
      arst_n      = 1'b0;
      $readmemh("testbench/core_golden.hex", golden);
      store_count = int'(golden[COUNT_IDX]);
      assert (store_count <= MAX_STORES)
         else note_failure("golden store count exceeds the store table");
      if (store_count > MAX_STORES) begin
         store_count = MAX_STORES;
      end
      // Program goes in after the model's own fill
      @(negedge clock);
      for (int i = 0; i < PROG_WORDS; i++) begin
         u_mem.mem[i] = golden[i];
      end
      repeat (RESET_CYCLES - 1) @(negedge clock);
      arst_n = 1'b1;
      while (!halted && cycles < TIMEOUT_CYCLES) begin
         @(negedge clock);
      end
      assert (halted)
         else note_failure($sformatf("timeout, o_halted still low after %0d cycles",
                                     TIMEOUT_CYCLES));
      if (halted) begin
         // Catch any store that shows up after halt
         repeat (DRAIN_CYCLES) @(negedge clock);
      end
      assert (store_idx == store_count)
         else note_failure($sformatf("missing stores, %0d of %0d seen",
                                     store_idx, store_count));
      $display("Summary: %0d errors, %0d of %0d stores seen in %0d cycles",
               errors, store_idx, store_count, cycles);
      if (errors == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

// File: testbench/tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model (
   input  logic               clock,
   input  core_pkg::mem_req_t i_req,
   input  core_pkg::mem_id_t  i_id,
   output logic               o_waitrequest,
   output core_pkg::word_t    o_rdata,
   output core_pkg::mem_id_t  o_rid
);

   localparam int          MEM_WORDS = 256;
   localparam logic [15:0] LFSR_SEED = 16'd17607;

   core_pkg::word_t   mem [MEM_WORDS];
   core_pkg::word_t   resp_data [$];
   core_pkg::mem_id_t resp_id [$];
   int                resp_due [$];
   logic [15:0]       lfsr;
   int                tick;

   // Fibonacci LFSR with taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] state);
      return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
   endfunction

   task automatic take_bit(output logic bit_out);
      lfsr    = lfsr_next(lfsr);
      bit_out = lfsr[0];
   endtask

   initial begin
      lfsr          = LFSR_SEED;
      tick          = 0;
      o_waitrequest = 1'b0;
      o_rdata       = '0;
      o_rid         = '0;
      // Fill words decode as no-ops
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem[i] = {4'hf, 4'h0, 8'(i), 8'(~i), 8'(i)};
      end
   end

   // Core registers its request, so what is seen here holds through the next rising edge
   always @(negedge clock) begin : bus_side
      logic stall;
      logic b0;
      logic b1;
      int   idx;
      int   k;
      tick = tick + 1;
      // At most one return per cycle in request order
      if (resp_due.size() != 0 && resp_due[0] <= tick) begin
         o_rdata <= resp_data.pop_front();
         o_rid   <= resp_id.pop_front();
         void'(resp_due.pop_front());
      end else begin
         o_rdata <= '0;
         o_rid   <= '0;
      end
      take_bit(b0);
      take_bit(b1);
      stall         = b0 && b1;
      o_waitrequest <= stall;
      idx           = int'(i_req.addr[7:0]);
      if (i_req.write && !stall) begin
         for (k = 0; k < 4; k++) begin
            if (i_req.mask[k]) begin
               mem[idx][8*k +: 8] = i_req.wdata[8*k +: 8];
            end
         end
      end else if (i_req.read && !stall) begin
         // Extra latency of 0 to 3 cycles
         take_bit(b0);
         take_bit(b1);
         resp_data.push_back(mem[idx]);
         resp_id.push_back(i_id);
         resp_due.push_back(tick + 1 + int'({b0, b1}));
      end
   end

endmodule

// File: vlog.f
hdl/core_pkg.sv
hdl/fetch_unit.sv
hdl/instr_queue.sv
hdl/exec_unit.sv
hdl/mem_port_mux.sv
hdl/core_top.sv
testbench/tb_mem_model.sv
testbench/tb_core.sv
